/* verilog/u2_pkg.sv */
// Shared definitions for the sample link
// Settings bus layout, register map, FIFO sizing and SERDES constants
package u2_pkg;

   ////////////////////////////////////////////////////////////
   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   // Register map
   localparam logic [SET_ADDR_W-1:0] SR_SER     = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SW  = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC = 8'd8;
   localparam logic [SET_ADDR_W-1:0] SR_CLEAR   = 8'd9;

   // Bits 4..1 under hardware control out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'b0001_1110;

   // SERDES control lines, enable sits in bit 3
   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } ser_ctrl_t;

   ////////////////////////////////////////////////////////////
   // Datapath
   localparam int SAMPLE_W   = 32;
   localparam int SER_W      = 16;
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_CNT_W = 5;

   // K28.5 comma in the low byte
   localparam logic [SER_W-1:0] SER_IDLE_WORD = 16'h50BC;

   ////////////////////////////////////////////////////////////
   // Readback
   localparam int RB_ADDR_W = 2;
   localparam logic [RB_ADDR_W-1:0] RB_STATUS = 2'd0;
   localparam logic [RB_ADDR_W-1:0] RB_COUNT  = 2'd1;
   localparam logic [RB_ADDR_W-1:0] RB_DROPS  = 2'd2;
   localparam logic [RB_ADDR_W-1:0] RB_COMPAT = 2'd3;

   // Bump when the register map or datapath changes
   localparam logic [31:0] COMPAT_NUM = 32'd4;

endpackage

/* verilog/setting_reg.sv */
// Settings register
// Loads its payload from the settings bus on an address match
module setting_reg #(
   parameter logic [u2_pkg::SET_ADDR_W-1:0] my_addr = '0,
   parameter type T = logic [7:0],
   parameter T at_reset = '0
) (
   input  logic             dsp_clk,
   input  logic             rst_i,
   input  u2_pkg::set_bus_t set_i,
   output T                 out_o,
   output logic             changed_o
);

   logic hit;

   assign hit = set_i.stb && (set_i.addr == my_addr);

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         out_o     <= at_reset;
         changed_o <= 1'b0;
      end else begin
         if (hit) begin
            // Payload comes from the low data bits
            out_o <= T'(set_i.data[$bits(T)-1:0]);
         end
         changed_o <= hit;
      end
   end

endmodule

/* verilog/sample_link_ctrl.sv */
// Receive sample control
// Qualifies samples by run and strobe, enqueues or drops them and keeps counts
module sample_link_ctrl (
   input  logic                        dsp_clk,
   input  logic                        rst_i,
   input  logic [u2_pkg::SAMPLE_W-1:0] sample_i,
   input  logic                        strobe_i,
   input  logic                        run_i,
   input  logic                        clear_i,
   input  logic                        enq_rdy_i,
   output logic                        enq_en_o,
   output logic [u2_pkg::SAMPLE_W-1:0] enq_dat_o,
   output logic                        overrun_o,
   output logic                        run_o,
   output logic [31:0]                 count_o,
   output logic [31:0]                 drops_o
);

   logic [u2_pkg::SAMPLE_W-1:0] sample_q;
   logic                        strobe_q;
   logic                        run_q;
   logic                        drop;

   ////////////////////////////////////////////////////////////
   // Input stage
   always_ff @(posedge dsp_clk) begin
      sample_q <= sample_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         strobe_q <= 1'b0;
         run_q    <= 1'b0;
      end else begin
         strobe_q <= strobe_i;
         run_q    <= run_i;
      end
   end

   // Valid sample goes to the FIFO only with room for both halves
   assign enq_en_o  = run_q && strobe_q && enq_rdy_i;
   assign drop      = run_q && strobe_q && !enq_rdy_i;
   assign enq_dat_o = sample_q;
   assign run_o     = run_q;

   ////////////////////////////////////////////////////////////
   // Counters and overrun pulse
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         overrun_o <= 1'b0;
         count_o   <= '0;
         drops_o   <= '0;
      end else begin
         overrun_o <= drop;
         if (clear_i) begin
            count_o <= '0;
            drops_o <= '0;
         end else begin
            if (enq_en_o)
               count_o <= count_o + 1'b1;
            if (drop)
               drops_o <= drops_o + 1'b1;
         end
      end
   end

   // FIFO room only shrinks on one of our enqueues
   a_room_kept: assert property (@(posedge dsp_clk) disable iff (rst_i)
      enq_rdy_i && !enq_en_o |=> enq_rdy_i);

endmodule

/* verilog/fifo_32_to_16.sv */
// Width converting FIFO
// Takes 32-bit samples and hands out 16-bit halves, upper half first
module fifo_32_to_16 (
   input  logic                          dsp_clk,
   input  logic                          rst_i,
   input  logic                          clear_i,
   input  logic                          enq_en_i,
   input  logic [u2_pkg::SAMPLE_W-1:0]   enq_dat_i,
   output logic                          enq_rdy_o,
   input  logic                          deq_en_i,
   output logic [u2_pkg::SER_W-1:0]      deq_dat_o,
   output logic                          deq_rdy_o,
   output logic [u2_pkg::FIFO_CNT_W-1:0] occupancy_o
);

   logic [u2_pkg::SER_W-1:0] mem [u2_pkg::FIFO_DEPTH];

   // Write side counts whole samples, read side counts halves
   // Both carry one wrap bit above the index
   logic [u2_pkg::FIFO_CNT_W-2:0] wr_word;
   logic [u2_pkg::FIFO_CNT_W-1:0] rd_half;

   ////////////////////////////////////////////////////////////
   // Status
   assign occupancy_o = {wr_word, 1'b0} - rd_half;
   assign enq_rdy_o   = occupancy_o <= u2_pkg::FIFO_CNT_W'(u2_pkg::FIFO_DEPTH - 2);
   assign deq_rdy_o   = occupancy_o != '0;
   assign deq_dat_o   = mem[rd_half[u2_pkg::FIFO_CNT_W-2:0]];

   ////////////////////////////////////////////////////////////
   // Storage
   always_ff @(posedge dsp_clk) begin
      if (enq_en_i) begin
         mem[{wr_word[u2_pkg::FIFO_CNT_W-3:0], 1'b0}] <=
            enq_dat_i[u2_pkg::SAMPLE_W-1:u2_pkg::SER_W];
         mem[{wr_word[u2_pkg::FIFO_CNT_W-3:0], 1'b1}] <= enq_dat_i[u2_pkg::SER_W-1:0];
      end
   end

   // Pointers, clear empties the store
   always_ff @(posedge dsp_clk) begin
      if (rst_i || clear_i) begin
         wr_word <= '0;
         rd_half <= '0;
      end else begin
         if (enq_en_i)
            wr_word <= wr_word + 1'b1;
         if (deq_en_i)
            rd_half <= rd_half + 1'b1;
      end
   end

   // Framer never pops an empty FIFO
   a_no_underflow: assert property (@(posedge dsp_clk) disable iff (rst_i)
      deq_en_i |-> deq_rdy_o);

endmodule

/* verilog/serdes_tx_framer.sv */
// SERDES transmit framer
// Registers one word per cycle, FIFO data when enabled or the comma idle
module serdes_tx_framer (
   input  logic                     dsp_clk,
   input  logic                     rst_i,
   input  logic                     enable_i,
   input  logic                     deq_rdy_i,
   input  logic [u2_pkg::SER_W-1:0] deq_dat_i,
   output logic                     deq_en_o,
   output logic [u2_pkg::SER_W-1:0] ser_t_o,
   output logic                     ser_tklsb_o,
   output logic                     ser_tkmsb_o
);

   assign deq_en_o = enable_i && deq_rdy_i;

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         ser_t_o     <= u2_pkg::SER_IDLE_WORD;
         ser_tklsb_o <= 1'b1;
      end else if (deq_en_o) begin
         ser_t_o     <= deq_dat_i;
         ser_tklsb_o <= 1'b0;
      end else begin
         // Comma in the low byte keeps the link aligned
         ser_t_o     <= u2_pkg::SER_IDLE_WORD;
         ser_tklsb_o <= 1'b1;
      end
   end

   // Upper byte never carries a K character here
   assign ser_tkmsb_o = 1'b0;

endmodule

/* verilog/status_panel.sv */
// Status panel
// LED source mux and registered readback of status words
module status_panel (
   input  logic                          dsp_clk,
   input  logic                          rst_i,
   input  logic [7:0]                    led_sw_i,
   input  logic [7:0]                    led_src_i,
   input  logic                          run_i,
   input  logic                          ser_enable_i,
   input  logic [u2_pkg::FIFO_CNT_W-1:0] occupancy_i,
   input  logic [31:0]                   count_i,
   input  logic [31:0]                   drops_i,
   input  logic [u2_pkg::RB_ADDR_W-1:0]  rb_addr_i,
   output logic [7:0]                    leds_o,
   output logic [31:0]                   rb_data_o
);

   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////
   // LEDs
   assign led_hw = {4'b0000, run_i, ser_enable_i, |occupancy_i, 1'b0};

   // Source bit 1 selects hardware, 0 selects software
   assign leds_o = (led_src_i & led_hw) | (~led_src_i & led_sw_i);

   ////////////////////////////////////////////////////////////
   // Readback
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         rb_data_o <= '0;
      end else begin
         unique case (rb_addr_i)
            u2_pkg::RB_STATUS:
               rb_data_o <= {{(32 - u2_pkg::FIFO_CNT_W){1'b0}}, occupancy_i};
            u2_pkg::RB_COUNT:  rb_data_o <= count_i;
            u2_pkg::RB_DROPS:  rb_data_o <= drops_i;
            u2_pkg::RB_COMPAT: rb_data_o <= u2_pkg::COMPAT_NUM;
         endcase
      end
   end

endmodule

/* verilog/u2_sample_link.sv */
// Sample link top level
// Settings registers, receive sample path to the SERDES transmitter, status
module u2_sample_link (
   input  logic                          dsp_clk,
   input  logic                          rst_i,
   input  logic                          set_stb_i,
   input  logic [u2_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [u2_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic [u2_pkg::SAMPLE_W-1:0]   sample_i,
   input  logic                          strobe_i,
   input  logic                          run_i,
   input  logic [u2_pkg::RB_ADDR_W-1:0]  rb_addr_i,
   output logic [7:0]                    leds_o,
   output logic [u2_pkg::SER_W-1:0]      ser_t_o,
   output logic                          ser_tklsb_o,
   output logic                          ser_tkmsb_o,
   output logic                          ser_enable_o,
   output logic                          ser_prbsen_o,
   output logic                          ser_loopen_o,
   output logic                          ser_rx_en_o,
   output logic                          overrun_o,
   output logic [31:0]                   rb_data_o
);

   u2_pkg::set_bus_t               set_bus;
   u2_pkg::ser_ctrl_t              ser_ctrl;
   logic [7:0]                     led_sw;
   logic [7:0]                     led_src;
   logic                           clear;
   logic                           run;
   logic                           enq_en;
   logic                           enq_rdy;
   logic [u2_pkg::SAMPLE_W-1:0]    enq_dat;
   logic                           deq_en;
   logic                           deq_rdy;
   logic [u2_pkg::SER_W-1:0]       deq_dat;
   logic [u2_pkg::FIFO_CNT_W-1:0]  occupancy;
   logic [31:0]                    count;
   logic [31:0]                    drops;

   assign set_bus = {set_stb_i, set_addr_i, set_data_i};

   assign ser_enable_o = ser_ctrl.enable;
   assign ser_prbsen_o = ser_ctrl.prbsen;
   assign ser_loopen_o = ser_ctrl.loopen;
   assign ser_rx_en_o  = ser_ctrl.rx_en;

   ////////////////////////////////////////////////////////////
   // Settings registers
   setting_reg #(.my_addr(u2_pkg::SR_SER), .T(u2_pkg::ser_ctrl_t)) sr_ser (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_bus),
      .out_o(ser_ctrl), .changed_o());

   setting_reg #(.my_addr(u2_pkg::SR_LED_SW), .T(logic [7:0])) sr_led_sw (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_bus),
      .out_o(led_sw), .changed_o());

   setting_reg #(.my_addr(u2_pkg::SR_LED_SRC), .T(logic [7:0]),
                 .at_reset(u2_pkg::LED_SRC_RESET)) sr_led_src (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_bus),
      .out_o(led_src), .changed_o());

   // Any write here flushes the sample path
   setting_reg #(.my_addr(u2_pkg::SR_CLEAR), .T(logic)) sr_clear (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .set_i(set_bus),
      .out_o(), .changed_o(clear));

   ////////////////////////////////////////////////////////////
   // Sample path
   sample_link_ctrl sample_link_ctrl_i (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .sample_i(sample_i), .strobe_i(strobe_i), .run_i(run_i), .clear_i(clear),
      .enq_rdy_i(enq_rdy), .enq_en_o(enq_en), .enq_dat_o(enq_dat),
      .overrun_o(overrun_o), .run_o(run), .count_o(count), .drops_o(drops));

   fifo_32_to_16 fifo_32_to_16_i (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .clear_i(clear),
      .enq_en_i(enq_en), .enq_dat_i(enq_dat), .enq_rdy_o(enq_rdy),
      .deq_en_i(deq_en), .deq_dat_o(deq_dat), .deq_rdy_o(deq_rdy),
      .occupancy_o(occupancy));

   serdes_tx_framer serdes_tx_framer_i (
      .dsp_clk(dsp_clk), .rst_i(rst_i), .enable_i(ser_ctrl.enable),
      .deq_rdy_i(deq_rdy), .deq_dat_i(deq_dat), .deq_en_o(deq_en),
      .ser_t_o(ser_t_o), .ser_tklsb_o(ser_tklsb_o), .ser_tkmsb_o(ser_tkmsb_o));

   ////////////////////////////////////////////////////////////
   // LEDs and readback
   status_panel status_panel_i (
      .dsp_clk(dsp_clk), .rst_i(rst_i),
      .led_sw_i(led_sw), .led_src_i(led_src),
      .run_i(run), .ser_enable_i(ser_ctrl.enable),
      .occupancy_i(occupancy), .count_i(count), .drops_i(drops),
      .rb_addr_i(rb_addr_i), .leds_o(leds_o), .rb_data_o(rb_data_o));

endmodule

/* test/tb_model.svh */
// Reference model for the sample link testbench
// Expected LEDs, SERDES half order, fill outcome and status word
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Hardware byte has run on bit 3, ser enable on bit 2, FIFO busy on bit 1
function automatic logic [7:0] expected_leds(input logic [7:0] sw, input logic [7:0] src,
                                             input logic run, input logic ser_en,
                                             input logic busy);
   logic [7:0] hw;
   logic [7:0] leds;
   int         b;
   hw    = 8'h00;
   hw[3] = run;
   hw[2] = ser_en;
   hw[1] = busy;
   for (b = 0; b < 8; b++) begin
      leds[b] = src[b] ? hw[b] : sw[b];
   end
   return leds;
endfunction

// Upper half goes out first
function automatic logic [15:0] upper_half(input logic [31:0] smp);
   return smp[31:16];
endfunction

function automatic logic [15:0] lower_half(input logic [31:0] smp);
   return smp[15:0];
endfunction

// Fill from empty with the link off, each sample needs two free halves
function automatic int accepted_in_fill(input int n, input int depth_halves);
   return (n < depth_halves / 2) ? n : depth_halves / 2;
endfunction

function automatic int dropped_in_fill(input int n, input int depth_halves);
   return n - accepted_in_fill(n, depth_halves);
endfunction

// Occupancy sits in the low bits of the status word
function automatic logic [31:0] status_word(input int occupancy);
   return 32'(occupancy);
endfunction

`endif

/* test/tb_u2_sample_link.sv */
// Testbench for the sample link
// Settings, LED mux, streaming, back-pressure and clear through the top level
module tb_u2_sample_link;
   timeunit 1ns;
   timeprecision 1ps;

   logic        dsp_clk;
   logic        rst_i;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic [31:0] sample_i;
   logic        strobe_i;
   logic        run_i;
   logic [1:0]  rb_addr_i;
   logic [7:0]  leds_o;
   logic [15:0] ser_t_o;
   logic        ser_tklsb_o;
   logic        ser_tkmsb_o;
   logic        ser_enable_o;
   logic        ser_prbsen_o;
   logic        ser_loopen_o;
   logic        ser_rx_en_o;
   logic        overrun_o;
   logic [31:0] rb_data_o;

   logic [15:0] exp_q [$];
   int          checks;
   int          errors;
   int          overrun_seen;
   int          i;
   logic [31:0] s;
   logic [31:0] rd;
   logic [31:0] drops_before;
   logic [7:0]  sw;
   logic [7:0]  src;
   logic [3:0]  ser;

   `include "tb_model.svh"

   u2_sample_link u2_sample_link_i (.*);

   initial dsp_clk = 1'b0;
   always #2 dsp_clk = ~dsp_clk;

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Starts just after a falling edge, ends after the write edge
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i = 1'b0;
   endtask

   task automatic read_back(input logic [1:0] addr, output logic [31:0] data);
      rb_addr_i = addr;
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   task automatic send_sample(input logic [31:0] smp, input int gap);
      sample_i = smp;
      strobe_i = 1'b1;
      @(negedge dsp_clk);
      strobe_i = 1'b0;
      repeat (gap) @(negedge dsp_clk);
   endtask

   task automatic wait_drained(input int max_cycles);
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < max_cycles) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("Timeout: %0d SERDES words never arrived", exp_q.size());
         $display("Some tests failed");
         $finish;
      end
   endtask

   task automatic expect_idle(input int cycles);
      repeat (cycles) begin
         @(negedge dsp_clk);
         check_value("idle tklsb", 32'(ser_tklsb_o), 32'd1);
         check_value("idle tkmsb", 32'(ser_tkmsb_o), 32'd0);
         check_value("idle word", 32'(ser_t_o), 32'h50BC);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // SERDES word compare and overrun count
   always @(negedge dsp_clk) begin
      if (!rst_i && ser_tklsb_o == 1'b0) begin
         check_value("data tkmsb", 32'(ser_tkmsb_o), 32'd0);
         if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected SERDES data word %h at t=%0t", ser_t_o, $time);
         end else begin
            check_value("serdes word", 32'(ser_t_o), 32'(exp_q.pop_front()));
         end
      end
      if (!rst_i && overrun_o)
         overrun_seen++;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   initial begin
      void'($urandom(32'h74f0));
      checks       = 0;
      errors       = 0;
      overrun_seen = 0;
      rst_i        = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      sample_i     = '0;
      strobe_i     = 1'b0;
      run_i        = 1'b0;
      rb_addr_i    = '0;
      repeat (2) @(negedge dsp_clk);
      rst_i = 1'b0;

      // After reset
      check_value("reset tklsb", 32'(ser_tklsb_o), 32'd1);
      check_value("reset word", 32'(ser_t_o), 32'h50BC);
      check_value("reset ser enable", 32'(ser_enable_o), 32'd0);
      check_value("reset leds", 32'(leds_o),
                  32'(expected_leds(8'h00, 8'h1E, 1'b0, 1'b0, 1'b0)));
      read_back(2'd3, rd);
      check_value("compat number", rd, 32'd4);

      // LED and SERDES control registers
      repeat (4) begin
         sw  = 8'($urandom());
         src = 8'($urandom());
         write_setting(8'd3, {24'($urandom()), sw});
         write_setting(8'd8, {24'($urandom()), src});
         check_value("leds", 32'(leds_o), 32'(expected_leds(sw, src, 1'b0, 1'b0, 1'b0)));
      end
      ser = 4'($urandom());
      write_setting(8'd1, {28'h0, ser});
      // Unused address must leave everything alone
      write_setting(8'd5, $urandom());
      check_value("ser controls", 32'({ser_enable_o, ser_prbsen_o, ser_loopen_o,
                  ser_rx_en_o}), 32'(ser));
      check_value("leds after ser", 32'(leds_o),
                  32'(expected_leds(sw, src, 1'b0, ser[3], 1'b0)));

      // Streaming with the link on
      write_setting(8'd1, 32'h8);
      run_i        = 1'b1;
      overrun_seen = 0;
      for (i = 0; i < 40; i++) begin
         s = $urandom();
         exp_q.push_back(upper_half(s));
         exp_q.push_back(lower_half(s));
         send_sample(s, 1 + $urandom() % 3);
      end
      wait_drained(200);
      read_back(2'd1, rd);
      check_value("sample count", rd, 32'd40);
      check_value("overruns while streaming", overrun_seen, 0);

      // Back-pressure with the link off
      write_setting(8'd1, 32'h0);
      read_back(2'd2, drops_before);
      overrun_seen = 0;
      for (i = 0; i < 12; i++) begin
         s = $urandom();
         if (i < accepted_in_fill(12, 16)) begin
            exp_q.push_back(upper_half(s));
            exp_q.push_back(lower_half(s));
         end
         send_sample(s, 0);
      end
      repeat (3) @(negedge dsp_clk);
      check_value("overrun pulses", overrun_seen, dropped_in_fill(12, 16));
      read_back(2'd2, rd);
      check_value("drop count", rd, drops_before + 32'(dropped_in_fill(12, 16)));
      read_back(2'd0, rd);
      check_value("full status", rd, status_word(2 * accepted_in_fill(12, 16)));
      // Run and FIFO busy show on the hardware LEDs
      src = 8'h1E;
      write_setting(8'd8, 32'(src));
      check_value("leds while full", 32'(leds_o),
                  32'(expected_leds(sw, src, 1'b1, 1'b0, 1'b1)));
      write_setting(8'd1, 32'h8);
      wait_drained(100);
      expect_idle(4);

      // Clear after a partial fill
      write_setting(8'd1, 32'h0);
      for (i = 0; i < 3; i++)
         send_sample($urandom(), 0);
      repeat (2) @(negedge dsp_clk);
      read_back(2'd0, rd);
      check_value("partial status", rd, status_word(6));
      write_setting(8'd9, 32'h1);
      @(negedge dsp_clk);
      read_back(2'd0, rd);
      check_value("status after clear", rd, status_word(0));
      read_back(2'd1, rd);
      check_value("count after clear", rd, 32'd0);
      read_back(2'd2, rd);
      check_value("drops after clear", rd, 32'd0);
      write_setting(8'd1, 32'h8);
      expect_idle(20);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* u2_sample_link.f */
+incdir+test
verilog/u2_pkg.sv
verilog/setting_reg.sv
verilog/sample_link_ctrl.sv
verilog/fifo_32_to_16.sv
verilog/serdes_tx_framer.sv
verilog/status_panel.sv
verilog/u2_sample_link.sv
test/tb_u2_sample_link.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/1ps
TOP        ?= tb_u2_sample_link
FILELIST   ?= u2_sample_link.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
